// File: verilog/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ---------------------------------------------------------------------------
// cache geometry
// ---------------------------------------------------------------------------

// byte address width
`define CACHE_ADDR_W 32

// one word per line
`define CACHE_DATA_W 32

// 16 lines per cache
`define CACHE_IDX_W 4

// byte offset inside a word
`define CACHE_OFF_W 2

// derived widths
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_IDX_W - `CACHE_OFF_W)
`define CACHE_LINES (1 << `CACHE_IDX_W)

`endif

// File: verilog/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

  // ---------------------------------------------------------------------------
  // vector types
  // ---------------------------------------------------------------------------

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_DATA_W-1:0] word_t;

  // line index, address bits 2 and up
  typedef logic [`CACHE_IDX_W-1:0] idx_t;

  // upper address bits kept per line
  typedef logic [`CACHE_TAG_W-1:0] tag_t;

  // ---------------------------------------------------------------------------
  // state encodings
  // ---------------------------------------------------------------------------

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_MISS
  } ic_state_t;

  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,
    DC_READ_MISS,
    DC_WRITE,
    DC_FLUSH
  } dc_state_t;

  // who holds the memory port
  typedef enum logic [1:0] {
    ARB_NONE,
    ARB_ICACHE,
    ARB_DCACHE
  } arb_owner_t;

endpackage

// File: verilog/icache.sv
`include "cache_cfg.svh"

module icache (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             icache_en_i,
  input  logic             icache_flush_i,
  input  logic             fetch_req_i,
  input  cache_pkg::addr_t fetch_addr_i,
  output logic             fetch_valid_o,
  output cache_pkg::word_t fetch_data_o,
  output logic             icache_miss_o,
  output logic             mem_req_o,
  output cache_pkg::addr_t mem_addr_o,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  cache_pkg::word_t mem_rdata_i
);

  import cache_pkg::*;

  ic_state_t               state_q;
  addr_t                   addr_q;
  logic [`CACHE_LINES-1:0] valid_q;
  tag_t                    tag_mem [`CACHE_LINES];
  word_t                   data_mem [`CACHE_LINES];
  logic                    granted_q;
  logic                    accept;
  logic                    hit;
  logic                    fill_done;
  idx_t                    idx;
  tag_t                    tag;

  assign idx = addr_q[`CACHE_OFF_W +: `CACHE_IDX_W];
  assign tag = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

  // the held request is not taken again while its valid pulse is out
  assign accept = (state_q == IC_IDLE) && !icache_flush_i && fetch_req_i && !fetch_valid_o;

  // a disabled cache never hits, so every fetch goes to memory
  assign hit = icache_en_i && valid_q[idx] && (tag_mem[idx] == tag);

  assign fill_done = (state_q == IC_MISS) && granted_q && mem_rvalid_i;

  // ---------------------------------------------------------------------------
  // memory request
  // ---------------------------------------------------------------------------

  assign mem_req_o  = (state_q == IC_MISS) && !granted_q;
  assign mem_addr_o = {addr_q[`CACHE_ADDR_W-1:`CACHE_OFF_W], {`CACHE_OFF_W{1'b0}}};

  // ---------------------------------------------------------------------------
  // control FSM
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= IC_IDLE;
      valid_q       <= '0;
      granted_q     <= 1'b0;
      fetch_valid_o <= 1'b0;
      icache_miss_o <= 1'b0;
    end else begin
      fetch_valid_o <= 1'b0;
      icache_miss_o <= 1'b0;
      case (state_q)
        IC_IDLE: begin
          if (icache_flush_i) begin
            valid_q <= '0;
          end else if (accept) begin
            state_q <= IC_LOOKUP;
          end
        end
        IC_LOOKUP: begin
          if (hit) begin
            fetch_valid_o <= 1'b1;
            state_q       <= IC_IDLE;
          end else begin
            icache_miss_o <= 1'b1;
            granted_q     <= 1'b0;
            state_q       <= IC_MISS;
          end
        end
        IC_MISS: begin
          if (mem_req_o && mem_gnt_i) begin
            granted_q <= 1'b1;
          end
          if (fill_done) begin
            fetch_valid_o <= 1'b1;
            granted_q     <= 1'b0;
            state_q       <= IC_IDLE;
            if (icache_en_i) begin
              valid_q[idx] <= 1'b1;
            end
          end
        end
        default: state_q <= IC_IDLE;
      endcase
    end
  end

  // address, fetch data and line arrays
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if ((state_q == IC_LOOKUP) && hit) begin
      fetch_data_o <= data_mem[idx];
    end
    if (fill_done) begin
      fetch_data_o <= mem_rdata_i;
      if (icache_en_i) begin
        tag_mem[idx]  <= tag;
        data_mem[idx] <= mem_rdata_i;
      end
    end
  end

endmodule

// File: verilog/wt_dcache.sv
`include "cache_cfg.svh"

module wt_dcache (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             dcache_flush_i,
  output logic             dcache_flush_ack_o,
  input  logic             dreq_i,
  input  logic             dwe_i,
  input  cache_pkg::addr_t daddr_i,
  input  cache_pkg::word_t dwdata_i,
  output logic             dack_o,
  output cache_pkg::word_t drdata_o,
  output logic             dcache_miss_o,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output cache_pkg::addr_t mem_addr_o,
  output cache_pkg::word_t mem_wdata_o,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  cache_pkg::word_t mem_rdata_i
);

  import cache_pkg::*;

  dc_state_t               state_q;
  addr_t                   addr_q;
  word_t                   wdata_q;
  logic                    we_q;
  logic [`CACHE_LINES-1:0] valid_q;
  tag_t                    tag_mem [`CACHE_LINES];
  word_t                   data_mem [`CACHE_LINES];
  logic                    granted_q;
  logic                    accept;
  logic                    hit;
  logic                    store_done;
  logic                    load_fill;
  idx_t                    idx;
  tag_t                    tag;

  assign idx = addr_q[`CACHE_OFF_W +: `CACHE_IDX_W];
  assign tag = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign hit = valid_q[idx] && (tag_mem[idx] == tag);

  // flush wins over a request in the same cycle
  assign accept = (state_q == DC_IDLE) && !dcache_flush_i && dreq_i && !dack_o;

  assign store_done = (state_q == DC_WRITE) && mem_gnt_i;
  assign load_fill  = (state_q == DC_READ_MISS) && granted_q && mem_rvalid_i;

  // ack is high for the single cycle spent in FLUSH
  assign dcache_flush_ack_o = (state_q == DC_FLUSH);

  // ---------------------------------------------------------------------------
  // memory request
  // ---------------------------------------------------------------------------

  assign mem_req_o   = (state_q == DC_WRITE) || ((state_q == DC_READ_MISS) && !granted_q);
  assign mem_we_o    = (state_q == DC_WRITE);
  assign mem_addr_o  = {addr_q[`CACHE_ADDR_W-1:`CACHE_OFF_W], {`CACHE_OFF_W{1'b0}}};
  assign mem_wdata_o = wdata_q;

  // ---------------------------------------------------------------------------
  // control FSM
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= DC_IDLE;
      valid_q       <= '0;
      granted_q     <= 1'b0;
      dack_o        <= 1'b0;
      dcache_miss_o <= 1'b0;
    end else begin
      dack_o        <= 1'b0;
      dcache_miss_o <= 1'b0;
      case (state_q)
        DC_IDLE: begin
          if (dcache_flush_i) begin
            valid_q <= '0;
            state_q <= DC_FLUSH;
          end else if (accept) begin
            state_q <= DC_LOOKUP;
          end
        end
        DC_LOOKUP: begin
          if (we_q) begin
            // every store goes out, hit or not
            state_q <= DC_WRITE;
          end else if (hit) begin
            dack_o  <= 1'b1;
            state_q <= DC_IDLE;
          end else begin
            dcache_miss_o <= 1'b1;
            granted_q     <= 1'b0;
            state_q       <= DC_READ_MISS;
          end
        end
        DC_READ_MISS: begin
          if (mem_req_o && mem_gnt_i) begin
            granted_q <= 1'b1;
          end
          if (load_fill) begin
            dack_o       <= 1'b1;
            granted_q    <= 1'b0;
            valid_q[idx] <= 1'b1;
            state_q      <= DC_IDLE;
          end
        end
        DC_WRITE: begin
          if (store_done) begin
            dack_o  <= 1'b1;
            state_q <= DC_IDLE;
          end
        end
        DC_FLUSH: state_q <= DC_IDLE;
        default:  state_q <= DC_IDLE;
      endcase
    end
  end

  // request payload, load data and line arrays
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= daddr_i;
      wdata_q <= dwdata_i;
      we_q    <= dwe_i;
    end
    if ((state_q == DC_LOOKUP) && !we_q && hit) begin
      drdata_o <= data_mem[idx];
    end
    if (load_fill) begin
      drdata_o      <= mem_rdata_i;
      tag_mem[idx]  <= tag;
      data_mem[idx] <= mem_rdata_i;
    end
    // no write allocate, only a hitting line takes the store
    if (store_done && hit) begin
      data_mem[idx] <= wdata_q;
    end
  end

endmodule

// File: verilog/mem_arbiter.sv
`include "cache_cfg.svh"

module mem_arbiter (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             ic_req_i,
  input  cache_pkg::addr_t ic_addr_i,
  output logic             ic_gnt_o,
  output logic             ic_rvalid_o,
  input  logic             dc_req_i,
  input  logic             dc_we_i,
  input  cache_pkg::addr_t dc_addr_i,
  input  cache_pkg::word_t dc_wdata_i,
  output logic             dc_gnt_o,
  output logic             dc_rvalid_o,
  output cache_pkg::word_t rdata_o,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output cache_pkg::addr_t mem_addr_o,
  output cache_pkg::word_t mem_wdata_o,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  cache_pkg::word_t mem_rdata_i
);

  import cache_pkg::*;

  // owner_q is set only while a granted read is outstanding
  arb_owner_t owner_q;
  arb_owner_t hold_q;
  arb_owner_t sel;
  logic       last_dc_q;
  logic       granted;

  // a request that waits for its grant keeps the port
  always_comb begin
    sel = ARB_NONE;
    if (hold_q != ARB_NONE) begin
      sel = hold_q;
    end else if (ic_req_i && dc_req_i) begin
      sel = last_dc_q ? ARB_ICACHE : ARB_DCACHE;
    end else if (ic_req_i) begin
      sel = ARB_ICACHE;
    end else if (dc_req_i) begin
      sel = ARB_DCACHE;
    end
  end

  // ---------------------------------------------------------------------------
  // memory port
  // ---------------------------------------------------------------------------

  assign mem_req_o   = (owner_q == ARB_NONE) && (sel != ARB_NONE);
  assign mem_we_o    = mem_req_o && (sel == ARB_DCACHE) && dc_we_i;
  assign mem_addr_o  = (sel == ARB_DCACHE) ? dc_addr_i : ic_addr_i;
  assign mem_wdata_o = dc_wdata_i;

  assign granted  = mem_req_o && mem_gnt_i;
  assign ic_gnt_o = granted && (sel == ARB_ICACHE);
  assign dc_gnt_o = granted && (sel == ARB_DCACHE);

  // read data is shared, the pulse goes to the owner only
  assign rdata_o     = mem_rdata_i;
  assign ic_rvalid_o = mem_rvalid_i && (owner_q == ARB_ICACHE);
  assign dc_rvalid_o = mem_rvalid_i && (owner_q == ARB_DCACHE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q   <= ARB_NONE;
      hold_q    <= ARB_NONE;
      last_dc_q <= 1'b0;
    end else begin
      if (granted) begin
        hold_q    <= ARB_NONE;
        last_dc_q <= (sel == ARB_DCACHE);
        // writes finish at the grant
        if (!mem_we_o) begin
          owner_q <= sel;
        end
      end else if (mem_req_o) begin
        hold_q <= sel;
      end
      if (mem_rvalid_i && (owner_q != ARB_NONE)) begin
        owner_q <= ARB_NONE;
      end
    end
  end

endmodule

// File: verilog/cache_subsystem.sv
`include "cache_cfg.svh"

module cache_subsystem (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // instruction side
  input  logic             icache_en_i,
  input  logic             icache_flush_i,
  output logic             icache_miss_o,
  input  logic             fetch_req_i,
  input  cache_pkg::addr_t fetch_addr_i,
  output logic             fetch_valid_o,
  output cache_pkg::word_t fetch_data_o,
  // data side
  input  logic             dcache_flush_i,
  output logic             dcache_flush_ack_o,
  output logic             dcache_miss_o,
  input  logic             dreq_i,
  input  logic             dwe_i,
  input  cache_pkg::addr_t daddr_i,
  input  cache_pkg::word_t dwdata_i,
  output logic             dack_o,
  output cache_pkg::word_t drdata_o,
  // external memory
  output logic             mem_req_o,
  output logic             mem_we_o,
  output cache_pkg::addr_t mem_addr_o,
  output cache_pkg::word_t mem_wdata_o,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  cache_pkg::word_t mem_rdata_i
);

  import cache_pkg::*;

  logic  ic_mreq;
  addr_t ic_maddr;
  logic  ic_mgnt;
  logic  ic_mrvalid;
  logic  dc_mreq;
  logic  dc_mwe;
  addr_t dc_maddr;
  word_t dc_mwdata;
  logic  dc_mgnt;
  logic  dc_mrvalid;
  word_t mrdata;

  // ---------------------------------------------------------------------------
  // caches
  // ---------------------------------------------------------------------------

  icache i_icache (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .icache_en_i    ( icache_en_i    ),
    .icache_flush_i ( icache_flush_i ),
    .fetch_req_i    ( fetch_req_i    ),
    .fetch_addr_i   ( fetch_addr_i   ),
    .fetch_valid_o  ( fetch_valid_o  ),
    .fetch_data_o   ( fetch_data_o   ),
    .icache_miss_o  ( icache_miss_o  ),
    .mem_req_o      ( ic_mreq        ),
    .mem_addr_o     ( ic_maddr       ),
    .mem_gnt_i      ( ic_mgnt        ),
    .mem_rvalid_i   ( ic_mrvalid     ),
    .mem_rdata_i    ( mrdata         )
  );

  wt_dcache i_dcache (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .dcache_flush_i     ( dcache_flush_i     ),
    .dcache_flush_ack_o ( dcache_flush_ack_o ),
    .dreq_i             ( dreq_i             ),
    .dwe_i              ( dwe_i              ),
    .daddr_i            ( daddr_i            ),
    .dwdata_i           ( dwdata_i           ),
    .dack_o             ( dack_o             ),
    .drdata_o           ( drdata_o           ),
    .dcache_miss_o      ( dcache_miss_o      ),
    .mem_req_o          ( dc_mreq            ),
    .mem_we_o           ( dc_mwe             ),
    .mem_addr_o         ( dc_maddr           ),
    .mem_wdata_o        ( dc_mwdata          ),
    .mem_gnt_i          ( dc_mgnt            ),
    .mem_rvalid_i       ( dc_mrvalid         ),
    .mem_rdata_i        ( mrdata             )
  );

  // ---------------------------------------------------------------------------
  // shared memory port
  // ---------------------------------------------------------------------------

  mem_arbiter i_mem_arbiter (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .ic_req_i     ( ic_mreq      ),
    .ic_addr_i    ( ic_maddr     ),
    .ic_gnt_o     ( ic_mgnt      ),
    .ic_rvalid_o  ( ic_mrvalid   ),
    .dc_req_i     ( dc_mreq      ),
    .dc_we_i      ( dc_mwe       ),
    .dc_addr_i    ( dc_maddr     ),
    .dc_wdata_i   ( dc_mwdata    ),
    .dc_gnt_o     ( dc_mgnt      ),
    .dc_rvalid_o  ( dc_mrvalid   ),
    .rdata_o      ( mrdata       ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  )
  );

endmodule

// File: bench/cache_subsystem_assertions.sv
module cache_subsystem_assertions (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             fetch_valid_o,
  input logic             dack_o,
  input logic             dcache_flush_i,
  input logic             dcache_flush_ack_o,
  input logic             mem_req_o,
  input logic             mem_we_o,
  input cache_pkg::addr_t mem_addr_o,
  input cache_pkg::word_t mem_wdata_o,
  input logic             mem_gnt_i,
  input logic             mem_rvalid_i
);

  // set while a granted read waits for its data
  logic rd_out_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_out_q <= 1'b0;
    end else if (mem_req_o && mem_gnt_i && !mem_we_o) begin
      rd_out_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      rd_out_q <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------------
  // memory port
  // ---------------------------------------------------------------------------

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)
      && (!mem_we_o || $stable(mem_wdata_o)))
    else $error("memory request changed before its grant");

  one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_out_q |-> !mem_req_o)
    else $error("memory request issued while a read is outstanding");

  // ---------------------------------------------------------------------------
  // core side pulses
  // ---------------------------------------------------------------------------

  fetch_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_valid_o |=> !fetch_valid_o)
    else $error("fetch_valid_o longer than one cycle");

  dack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dack_o |=> !dack_o)
    else $error("dack_o longer than one cycle");

  flush_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dcache_flush_i |=> dcache_flush_ack_o)
    else $error("flush acknowledge not one cycle after flush");

  flush_ack_origin: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dcache_flush_ack_o |-> $past(dcache_flush_i))
    else $error("flush acknowledge without a flush the cycle before");

endmodule

bind cache_subsystem cache_subsystem_assertions u_assertions (
  .clk_i              ( clk_i              ),
  .rst_n_i            ( rst_n_i            ),
  .fetch_valid_o      ( fetch_valid_o      ),
  .dack_o             ( dack_o             ),
  .dcache_flush_i     ( dcache_flush_i     ),
  .dcache_flush_ack_o ( dcache_flush_ack_o ),
  .mem_req_o          ( mem_req_o          ),
  .mem_we_o           ( mem_we_o           ),
  .mem_addr_o         ( mem_addr_o         ),
  .mem_wdata_o        ( mem_wdata_o        ),
  .mem_gnt_i          ( mem_gnt_i          ),
  .mem_rvalid_i       ( mem_rvalid_i       )
);

// File: bench/cache_subsystem_tb.sv
`include "cache_cfg.svh"

module cache_subsystem_tb;

  import cache_pkg::*;

  localparam int TIMEOUT = 200;

  logic  clk_i;
  logic  rst_n_i;
  logic  icache_en_i;
  logic  icache_flush_i;
  logic  icache_miss_o;
  logic  fetch_req_i;
  addr_t fetch_addr_i;
  logic  fetch_valid_o;
  word_t fetch_data_o;
  logic  dcache_flush_i;
  logic  dcache_flush_ack_o;
  logic  dcache_miss_o;
  logic  dreq_i;
  logic  dwe_i;
  addr_t daddr_i;
  word_t dwdata_i;
  logic  dack_o;
  word_t drdata_o;
  logic  mem_req_o;
  logic  mem_we_o;
  addr_t mem_addr_o;
  word_t mem_wdata_o;
  logic  mem_gnt_i;
  logic  mem_rvalid_i;
  word_t mem_rdata_i;

  integer seed;
  int     checks;
  int     errors;
  int     tests;
  int     writes;

  // memory model state and the expected memory contents
  word_t  mem_array [256];
  word_t  ref_mem [256];
  logic   rd_busy;
  int     rd_wait;
  int     rd_word;
  int     gnt_wait;
  logic   gnt_prev;

  // reference cache arrays with tags held as word indices
  logic   iv [16];
  int     itag [16];
  logic   dv [16];
  int     dtag [16];

  cache_subsystem dut0 (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    if (r < 0) begin
      r = -r;
    end
    return r % n;
  endfunction

  function automatic word_t fill_word(input int i);
    return (word_t'(i) * 32'h9e3779b1) ^ 32'hc0de0000;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $finish;
  endtask

  // ---------------------------------------------------------------------------
  // memory model driven on the falling edge
  // ---------------------------------------------------------------------------

  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
      rd_busy      = 1'b0;
      gnt_wait     = -1;
    end else begin
      gnt_prev     = mem_gnt_i;
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
      if (rd_busy) begin
        if (rd_wait == 0) begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem_array[rd_word];
          rd_busy      = 1'b0;
        end else begin
          rd_wait--;
        end
      end else if (mem_req_o && !gnt_prev) begin
        if (gnt_wait < 0) begin
          gnt_wait = rand_below(4);
        end
        if (gnt_wait == 0) begin
          mem_gnt_i = 1'b1;
          gnt_wait  = -1;
          if (mem_we_o) begin
            mem_array[int'(mem_addr_o[9:2])] = mem_wdata_o;
            writes++;
          end else begin
            rd_busy = 1'b1;
            rd_word = int'(mem_addr_o[9:2]);
            rd_wait = rand_below(4);
          end
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // core side tasks that start and end on a falling edge
  // ---------------------------------------------------------------------------

  task automatic fetch_word(input int w);
    int   idx;
    int   cycles;
    int   misses;
    logic exp_hit;
    logic done;
    idx     = w % 16;
    exp_hit = icache_en_i && iv[idx] && (itag[idx] == w);
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr_t'(w * 4);
    cycles = 0;
    misses = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      cycles++;
      if (icache_miss_o) begin
        misses++;
      end
      if (fetch_valid_o) begin
        done = 1'b1;
      end else if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout: fetch_valid_o never came for word %0d", w));
      end
    end
    fetch_req_i = 1'b0;
    check(fetch_data_o, ref_mem[w], "fetch data");
    check(32'(misses), exp_hit ? 32'd0 : 32'd1, "icache miss pulses");
    if (exp_hit) begin
      check(32'(cycles), 32'd2, "icache hit latency");
    end else if (icache_en_i) begin
      iv[idx]   = 1'b1;
      itag[idx] = w;
    end
    @(negedge clk_i);
  endtask

  task automatic data_access(input logic we, input int w, input word_t wd);
    int   idx;
    int   cycles;
    int   misses;
    int   writes_before;
    logic exp_hit;
    logic done;
    idx     = w % 16;
    exp_hit = dv[idx] && (dtag[idx] == w);
    writes_before = writes;
    dreq_i   = 1'b1;
    dwe_i    = we;
    daddr_i  = addr_t'(w * 4);
    dwdata_i = wd;
    cycles = 0;
    misses = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      cycles++;
      if (dcache_miss_o) begin
        misses++;
      end
      if (dack_o) begin
        done = 1'b1;
      end else if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout: dack_o never came for word %0d", w));
      end
    end
    dreq_i = 1'b0;
    if (we) begin
      // write through with no allocation on a miss
      ref_mem[w] = wd;
      check(mem_array[w], wd, "memory after store");
      check(32'(writes - writes_before), 32'd1, "memory writes per store");
      check(32'(misses), 32'd0, "dcache miss pulses on store");
    end else begin
      check(drdata_o, ref_mem[w], "load data");
      check(32'(misses), exp_hit ? 32'd0 : 32'd1, "dcache miss pulses");
      if (exp_hit) begin
        check(32'(cycles), 32'd2, "dcache hit latency");
      end else begin
        dv[idx]   = 1'b1;
        dtag[idx] = w;
      end
    end
    @(negedge clk_i);
  endtask

  task automatic report(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial begin
    int e0;
    int w;
    seed = 589;
    checks = 0;
    errors = 0;
    tests  = 0;
    writes = 0;
    rst_n_i        = 1'b0;
    icache_en_i    = 1'b1;
    icache_flush_i = 1'b0;
    fetch_req_i    = 1'b0;
    fetch_addr_i   = '0;
    dcache_flush_i = 1'b0;
    dreq_i         = 1'b0;
    dwe_i          = 1'b0;
    daddr_i        = '0;
    dwdata_i       = '0;
    mem_gnt_i      = 1'b0;
    mem_rvalid_i   = 1'b0;
    mem_rdata_i    = '0;
    for (int i = 0; i < 256; i++) begin
      mem_array[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end
    for (int i = 0; i < 16; i++) begin
      iv[i] = 1'b0;
      dv[i] = 1'b0;
      itag[i] = 0;
      dtag[i] = 0;
    end
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // instruction words live in 0..31 and data words in 128..159
    e0 = errors;
    for (int i = 0; i < 60; i++) begin
      fetch_word(rand_below(32));
    end
    report("instruction fetch", e0);

    e0 = errors;
    // lines 0..7 hold words 16..23 so that a bypass fill would show
    for (int i = 0; i < 8; i++) begin
      fetch_word(16 + i);
    end
    icache_en_i = 1'b0;
    for (int i = 0; i < 8; i++) begin
      fetch_word(i);
    end
    icache_en_i = 1'b1;
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 8; i++) begin
        fetch_word(i);
      end
    end
    icache_flush_i = 1'b1;
    @(negedge clk_i);
    icache_flush_i = 1'b0;
    for (int i = 0; i < 16; i++) begin
      iv[i] = 1'b0;
    end
    for (int i = 0; i < 8; i++) begin
      fetch_word(i);
    end
    report("icache bypass and flush", e0);

    e0 = errors;
    for (int i = 0; i < 80; i++) begin
      data_access(rand_below(2) == 1, 128 + rand_below(32), word_t'($random(seed)));
    end
    report("data loads and write-through", e0);

    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      data_access(1'b0, 128 + i, '0);
    end
    dcache_flush_i = 1'b1;
    @(negedge clk_i);
    check(32'(dcache_flush_ack_o), 32'd1, "flush ack one cycle after flush");
    dcache_flush_i = 1'b0;
    @(negedge clk_i);
    check(32'(dcache_flush_ack_o), 32'd0, "flush ack is a single pulse");
    for (int i = 0; i < 16; i++) begin
      dv[i] = 1'b0;
    end
    for (int i = 0; i < 8; i++) begin
      data_access(1'b0, 128 + i, '0);
    end
    report("data flush", e0);

    e0 = errors;
    for (int i = 0; i < 30; i++) begin
      w = 128 + rand_below(32);
      fork
        fetch_word(rand_below(32));
        data_access(rand_below(2) == 1, w, word_t'($random(seed)));
      join
    end
    report("concurrent traffic", e0);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: cache_subsystem.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/icache.sv
verilog/wt_dcache.sv
verilog/mem_arbiter.sv
verilog/cache_subsystem.sv
bench/cache_subsystem_assertions.sv
bench/cache_subsystem_tb.sv

// File: Makefile
SOURCES = cache_subsystem.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vcache_subsystem_tb

obj_dir/Vcache_subsystem_tb: $(SOURCES)
	verilator --binary --timing --assert -f cache_subsystem.f \
		--top-module cache_subsystem_tb -o Vcache_subsystem_tb

run: obj_dir/Vcache_subsystem_tb
	./obj_dir/Vcache_subsystem_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
